// File: all.f
hdl/dram_timing_pkg.sv
hdl/dram_cmd_pkg.sv
hdl/request_router.sv
hdl/bank_timing_control.sv
hdl/bank_engine.sv
hdl/command_arbiter.sv
hdl/dram_sched_top.sv
tb/dram_sched_tb.sv

// File: hdl/bank_engine.sv
module bank_engine
    import dram_cmd_pkg::*;
(
    input  logic             clk,
    input  logic             nRST,
    input  logic             start,
    input  logic             start_write,
    input  logic [ROW_W-1:0] start_row,
    input  logic             cmd_grant,
    output logic             bank_ready,
    output logic             cmd_req,
    output dram_op_e         cmd_op,
    output logic [ROW_W-1:0] cmd_row,
    output logic             wr_en,
    output logic             rd_done
);
    bank_state_e state;
    bank_state_e next_state;

    logic             write_q;
    logic [ROW_W-1:0] row_q;

    logic rf_req;
    logic act_done;
    logic wr_done;
    logic pre_done;
    logic ref_done;

    bank_timing_control timing_i (
        .clk      (clk),
        .nRST     (nRST),
        .state    (state),
        .cmd_grant(cmd_grant),
        .rf_req   (rf_req),
        .act_done (act_done),
        .rd_done  (rd_done),
        .wr_done  (wr_done),
        .pre_done (pre_done),
        .ref_done (ref_done),
        .wr_en    (wr_en)
    );

    always_ff @(posedge clk, negedge nRST) begin
        if (!nRST) begin
            state <= IDLE;
        end else begin
            state <= next_state;
        end
    end

    // request held for the whole sequence
    always_ff @(posedge clk) begin
        if (state == IDLE && start) begin
            write_q <= start_write;
            row_q <= start_row;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            IDLE: begin
                // a start was granted on last cycle's ready, so it wins
                if (start) begin
                    next_state = ACTIVATE;
                end else if (rf_req) begin
                    next_state = REFRESH;
                end
            end
            ACTIVATE:    if (cmd_grant) next_state = ACTIVATING;
            ACTIVATING:  if (act_done) next_state = write_q ? WRITE : READ;
            READ:        if (cmd_grant) next_state = READING;
            READING:     if (rd_done) next_state = PRECHARGE;
            WRITE:       if (cmd_grant) next_state = WRITING;
            WRITING:     if (wr_done) next_state = PRECHARGE;
            PRECHARGE:   if (cmd_grant) next_state = PRECHARGING;
            PRECHARGING: if (pre_done) next_state = IDLE;
            REFRESH:     if (cmd_grant) next_state = REFRESHING;
            REFRESHING:  if (ref_done) next_state = IDLE;
            default:     next_state = IDLE;
        endcase
    end

    // command states ask the arbiter for the bus
    always_comb begin
        case (state)
            ACTIVATE:  cmd_op = OP_ACT;
            READ:      cmd_op = OP_RD;
            WRITE:     cmd_op = OP_WR;
            PRECHARGE: cmd_op = OP_PRE;
            REFRESH:   cmd_op = OP_REF;
            default:   cmd_op = OP_NOP;
        endcase
    end

    assign cmd_req = (cmd_op != OP_NOP);
    assign cmd_row = row_q;
    assign bank_ready = (state == IDLE) && !rf_req;

endmodule

// File: hdl/bank_timing_control.sv
module bank_timing_control
    import dram_cmd_pkg::*;
    import dram_timing_pkg::*;
(
    input  logic        clk,
    input  logic        nRST,
    input  bank_state_e state,
    input  logic        cmd_grant,
    output logic        rf_req,
    output logic        act_done,
    output logic        rd_done,
    output logic        wr_done,
    output logic        pre_done,
    output logic        ref_done,
    output logic        wr_en
);
    logic [CNT_W-1:0] time_load;
    logic [CNT_W-1:0] time_count;
    logic             time_last;

    logic [CNT_W-1:0] rf_count;
    logic [CNT_W-1:0] rf_limit;
    logic             in_refresh;

    // delay for the command about to be granted
    always_comb begin
        case (state)
            ACTIVATE:  time_load = T_RCD;
            READ:      time_load = T_RL + T_BURST;
            WRITE:     time_load = T_WL + T_BURST;
            PRECHARGE: time_load = T_RP;
            REFRESH:   time_load = T_RFC;
            default:   time_load = '0;
        endcase
    end

    // load on grant, count down to zero and stay there
    always_ff @(posedge clk, negedge nRST) begin
        if (!nRST) begin
            time_count <= '0;
        end else if (cmd_grant) begin
            time_count <= time_load;
        end else if (time_count != '0) begin
            time_count <= time_count - 1'b1;
        end
    end

    // last cycle of the wait comes L cycles after the grant
    assign time_last = (time_count == CNT_W'(1));

    always_comb begin
        act_done = (state == ACTIVATING) && time_last;
        rd_done = (state == READING) && time_last;
        wr_done = (state == WRITING) && time_last;
        pre_done = (state == PRECHARGING) && time_last;
        ref_done = (state == REFRESHING) && time_last;
        // strobe once the write latency has run out
        wr_en = (state == WRITING) && (time_count == T_BURST);
    end

    assign in_refresh = (state == REFRESH) || (state == REFRESHING);

    always_ff @(posedge clk, negedge nRST) begin
        if (!nRST) begin
            rf_count <= '0;
            rf_limit <= T_REFI;
        end else begin
            rf_count <= in_refresh ? '0 : rf_count + 1'b1;
            // count is still intact only in the first REFRESH cycle
            if (state == REFRESH && rf_count != '0) begin
                if (rf_count > T_REFI) begin
                    // pull the next refresh in by the overshoot when late
                    rf_limit <= T_REFI - (rf_count - T_REFI);
                end else begin
                    rf_limit <= T_REFI;
                end
            end
        end
    end

    assign rf_req = (rf_count >= rf_limit) && (state != REFRESH);

endmodule

// File: hdl/command_arbiter.sv
module command_arbiter
    import dram_cmd_pkg::*;
(
    input  logic                            clk,
    input  logic                            nRST,
    input  logic     [NUM_BANKS-1:0]        cmd_req,
    input  dram_op_e [NUM_BANKS-1:0]        cmd_op,
    input  logic     [NUM_BANKS-1:0][ROW_W-1:0] cmd_row,
    output logic     [NUM_BANKS-1:0]        cmd_grant,
    output dram_op_e                        dram_cmd,
    output logic     [BANK_W-1:0]           dram_bank,
    output logic     [ROW_W-1:0]            dram_row
);
    logic [BANK_W-1:0] rr_ptr;
    logic [BANK_W-1:0] sel;
    logic              found;

    // search starts one past the last bank granted
    always_comb begin
        logic [BANK_W-1:0] idx;
        found = 1'b0;
        sel = '0;
        for (int i = 1; i <= NUM_BANKS; i++) begin
            idx = rr_ptr + BANK_W'(i);
            if (!found && cmd_req[idx]) begin
                found = 1'b1;
                sel = idx;
            end
        end
    end

    always_comb begin
        cmd_grant = '0;
        if (found) begin
            cmd_grant[sel] = 1'b1;
        end
    end

    always_ff @(posedge clk, negedge nRST) begin
        if (!nRST) begin
            rr_ptr <= BANK_W'(NUM_BANKS - 1);
            dram_cmd <= OP_NOP;
        end else begin
            dram_cmd <= found ? cmd_op[sel] : OP_NOP;
            if (found) begin
                rr_ptr <= sel;
            end
        end
    end

    // bank and row only mean something next to a command
    always_ff @(posedge clk) begin
        if (found) begin
            dram_bank <= sel;
            dram_row <= cmd_row[sel];
        end
    end

endmodule

// File: hdl/dram_cmd_pkg.sv
package dram_cmd_pkg;

    localparam int NUM_BANKS = 4;
    localparam int BANK_W = 2;
    localparam int ROW_W = 14;

    // per-bank close-page sequence
    typedef enum logic [3:0] {
        IDLE,
        ACTIVATE,
        ACTIVATING,
        READ,
        READING,
        WRITE,
        WRITING,
        PRECHARGE,
        PRECHARGING,
        REFRESH,
        REFRESHING
    } bank_state_e;

    // opcodes on the DRAM command bus
    typedef enum logic [2:0] {
        OP_NOP,
        OP_ACT,
        OP_RD,
        OP_WR,
        OP_PRE,
        OP_REF
    } dram_op_e;

endpackage

// File: hdl/dram_sched_top.sv
module dram_sched_top
    import dram_cmd_pkg::*;
(
    input  logic                 clk,
    input  logic                 nRST,
    input  logic                 req_valid,
    input  logic                 req_write,
    input  logic [BANK_W-1:0]    req_bank,
    input  logic [ROW_W-1:0]     req_row,
    output logic                 req_ack,
    output dram_op_e             dram_cmd,
    output logic [BANK_W-1:0]    dram_bank,
    output logic [ROW_W-1:0]     dram_row,
    output logic [NUM_BANKS-1:0] wr_en,
    output logic [NUM_BANKS-1:0] rd_done
);
    logic [NUM_BANKS-1:0]            bank_ready;
    logic [NUM_BANKS-1:0]            start;
    logic                            start_write;
    logic [ROW_W-1:0]                start_row;
    logic [NUM_BANKS-1:0]            cmd_req;
    dram_op_e [NUM_BANKS-1:0]        cmd_op;
    logic [NUM_BANKS-1:0][ROW_W-1:0] cmd_row;
    logic [NUM_BANKS-1:0]            cmd_grant;

    request_router router_i (
        .clk        (clk),
        .nRST       (nRST),
        .req_valid  (req_valid),
        .req_write  (req_write),
        .req_bank   (req_bank),
        .req_row    (req_row),
        .bank_ready (bank_ready),
        .req_ack    (req_ack),
        .start      (start),
        .start_write(start_write),
        .start_row  (start_row)
    );

    for (genvar b = 0; b < NUM_BANKS; b++) begin : g_bank
        bank_engine engine_i (
            .clk        (clk),
            .nRST       (nRST),
            .start      (start[b]),
            .start_write(start_write),
            .start_row  (start_row),
            .cmd_grant  (cmd_grant[b]),
            .bank_ready (bank_ready[b]),
            .cmd_req    (cmd_req[b]),
            .cmd_op     (cmd_op[b]),
            .cmd_row    (cmd_row[b]),
            .wr_en      (wr_en[b]),
            .rd_done    (rd_done[b])
        );
    end

    command_arbiter arbiter_i (
        .clk      (clk),
        .nRST     (nRST),
        .cmd_req  (cmd_req),
        .cmd_op   (cmd_op),
        .cmd_row  (cmd_row),
        .cmd_grant(cmd_grant),
        .dram_cmd (dram_cmd),
        .dram_bank(dram_bank),
        .dram_row (dram_row)
    );

endmodule

// File: hdl/dram_timing_pkg.sv
package dram_timing_pkg;

    // width of the command delay and refresh interval counters
    localparam int CNT_W = 10;

    // ACT to READ/WRITE, tAL taken as zero
    localparam logic [CNT_W-1:0] T_RCD = CNT_W'(6);

    // read and write latency
    localparam logic [CNT_W-1:0] T_RL = CNT_W'(8);
    localparam logic [CNT_W-1:0] T_WL = CNT_W'(6);

    // burst length in clocks
    localparam logic [CNT_W-1:0] T_BURST = CNT_W'(4);

    // precharge and refresh cycle time
    localparam logic [CNT_W-1:0] T_RP = CNT_W'(6);
    localparam logic [CNT_W-1:0] T_RFC = CNT_W'(40);

    // average refresh interval, kept short
    localparam logic [CNT_W-1:0] T_REFI = CNT_W'(300);

endpackage

// File: hdl/request_router.sv
module request_router
    import dram_cmd_pkg::*;
(
    input  logic                 clk,
    input  logic                 nRST,
    input  logic                 req_valid,
    input  logic                 req_write,
    input  logic [BANK_W-1:0]    req_bank,
    input  logic [ROW_W-1:0]     req_row,
    input  logic [NUM_BANKS-1:0] bank_ready,
    output logic                 req_ack,
    output logic [NUM_BANKS-1:0] start,
    output logic                 start_write,
    output logic [ROW_W-1:0]     start_row
);
    logic ack_pending;
    logic accept;

    // host still holds the request during its ack cycle
    assign accept = req_valid && bank_ready[req_bank] && !ack_pending;

    always_ff @(posedge clk, negedge nRST) begin
        if (!nRST) begin
            ack_pending <= 1'b0;
            start <= '0;
        end else begin
            ack_pending <= accept;
            start <= '0;
            if (accept) begin
                start[req_bank] <= 1'b1;
            end
        end
    end

    // request fields go out alongside the start pulse
    always_ff @(posedge clk) begin
        if (accept) begin
            start_write <= req_write;
            start_row <= req_row;
        end
    end

    assign req_ack = ack_pending;

endmodule

// File: run_sim.sh
#!/bin/sh
# build and run the DRAM scheduler testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --top-module dram_sched_tb -f all.f -o dram_sched_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/dram_sched_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
fi

if grep -q "Regression passed" "$LOG"; then
    exit 0
fi
exit 1

// File: tb/dram_sched_tb.sv
module dram_sched_tb
    import dram_cmd_pkg::*;
    import dram_timing_pkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int NUM_REQ = 200;
    localparam int SEQ_WORST = 60;
    localparam int REF_MAX = int'(T_REFI) + int'(T_RFC) + SEQ_WORST;
    localparam int WATCHDOG_CYCLES = NUM_REQ * (SEQ_WORST + 40)
        + (NUM_REQ * (SEQ_WORST + 40) / int'(T_REFI) + 1) * (int'(T_RFC) + SEQ_WORST);
    // model phase of each bank
    localparam int PH_FREE = 0;
    localparam int PH_ACT = 1;
    localparam int PH_CMD = 2;
    localparam int PH_PRE = 3;

    logic                 clk;
    logic                 nRST;
    logic                 req_valid;
    logic                 req_write;
    logic [BANK_W-1:0]    req_bank;
    logic [ROW_W-1:0]     req_row;
    logic                 req_ack;
    dram_op_e             dram_cmd;
    logic [BANK_W-1:0]    dram_bank;
    logic [ROW_W-1:0]     dram_row;
    logic [NUM_BANKS-1:0] wr_en;
    logic [NUM_BANKS-1:0] rd_done;

    int               cycle = 0;
    int               last_grant = NUM_BANKS - 1;
    int               phase[NUM_BANKS];
    logic [ROW_W-1:0] exp_row[NUM_BANKS];
    logic             exp_write[NUM_BANKS];
    dram_op_e         last_op[NUM_BANKS];
    int               last_cycle[NUM_BANKS];
    int               due[NUM_BANKS];
    int               wr_due[NUM_BANKS];
    int               rd_due[NUM_BANKS];
    int               last_ref[NUM_BANKS];
    int               ref_count[NUM_BANKS];

    dram_sched_top dram_sched_top_i (
        .clk      (clk),
        .nRST     (nRST),
        .req_valid(req_valid),
        .req_write(req_write),
        .req_bank (req_bank),
        .req_row  (req_row),
        .req_ack  (req_ack),
        .dram_cmd (dram_cmd),
        .dram_bank(dram_bank),
        .dram_row (dram_row),
        .wr_en    (wr_en),
        .rd_done  (rd_done)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) cycle <= cycle + 1;

    task automatic stop_with_failure();
        $display("Regression failed");
        $fatal(1);
    endtask

    task automatic check_op(string name, dram_op_e got, dram_op_e exp);
        if (got != exp) begin
            $display("** Error at %0t: %s = %s, expected %s", $time, name, got.name(), exp.name());
            stop_with_failure();
        end
    endtask

    task automatic check_row(string name, logic [ROW_W-1:0] got, logic [ROW_W-1:0] exp);
        if (got !== exp) begin
            $display("** Error at %0t: %s = %0h, expected %0h", $time, name, got, exp);
            stop_with_failure();
        end
    endtask

    task automatic check_gap(string name, int got, int min_gap);
        if (got < min_gap) begin
            $display("** Error at %0t: %s = %0d, expected at least %0d", $time, name, got,
                     min_gap);
            stop_with_failure();
        end
    endtask

    task automatic check_bit(string name, logic got, logic exp);
        if (got !== exp) begin
            $display("** Error at %0t: %s = %b, expected %b", $time, name, got, exp);
            stop_with_failure();
        end
    endtask

    // counter load for each command
    function automatic int load_cycles(dram_op_e op);
        case (op)
            OP_ACT:  return int'(T_RCD);
            OP_RD:   return int'(T_RL) + int'(T_BURST);
            OP_WR:   return int'(T_WL) + int'(T_BURST);
            OP_PRE:  return int'(T_RP);
            OP_REF:  return int'(T_RFC);
            default: return 0;
        endcase
    endfunction

    // position in round-robin order after the last grant
    function automatic int rr_distance(int b);
        return (b - last_grant - 1 + NUM_BANKS) % NUM_BANKS;
    endfunction

    function automatic bit all_quiet();
        for (int b = 0; b < NUM_BANKS; b++) begin
            if (phase[b] != PH_FREE || wr_due[b] >= 0 || rd_due[b] >= 0) return 1'b0;
        end
        return 1'b1;
    endfunction

    task automatic accept_request(int b, logic [ROW_W-1:0] row, logic write);
        if (phase[b] != PH_FREE) begin
            $display("request acknowledged while bank %0d was still busy", b);
            stop_with_failure();
        end
        phase[b] = PH_ACT;
        exp_row[b] = row;
        exp_write[b] = write;
        // start goes out with the ack, ACT can be granted one cycle later
        due[b] = cycle + 2;
    endtask

    task automatic bus_command(int b, dram_op_e op, logic [ROW_W-1:0] row);
        if (last_op[b] != OP_NOP) begin
            check_gap($sformatf("bank %0d command gap", b), cycle - last_cycle[b],
                      load_cycles(last_op[b]) + 1);
        end
        case (phase[b])
            PH_FREE: begin
                check_op("dram_cmd", op, OP_REF);
                last_ref[b] = cycle;
                ref_count[b]++;
            end
            PH_ACT: begin
                check_op("dram_cmd", op, OP_ACT);
                phase[b] = PH_CMD;
            end
            PH_CMD: begin
                check_op("dram_cmd", op, exp_write[b] ? OP_WR : OP_RD);
                // grant was one cycle before the bus shows the command
                if (exp_write[b]) wr_due[b] = cycle + load_cycles(OP_WR) - int'(T_BURST);
                else rd_due[b] = cycle + load_cycles(OP_RD) - 1;
                phase[b] = PH_PRE;
            end
            default: begin
                check_op("dram_cmd", op, OP_PRE);
                phase[b] = PH_FREE;
            end
        endcase
        if (op != OP_REF) check_row("dram_row", row, exp_row[b]);
        last_op[b] = op;
        last_cycle[b] = cycle;
        due[b] = cycle + load_cycles(op) + 1;
        last_grant = b;
    endtask

    task automatic observe_cycle();
        int cmd_bank;
        cmd_bank = (dram_cmd != OP_NOP) ? int'(dram_bank) : -1;
        // banks known to be requesting must be served or lose fairly
        for (int b = 0; b < NUM_BANKS; b++) begin
            if (phase[b] != PH_FREE && cycle >= due[b] && b != cmd_bank) begin
                if (cmd_bank < 0) begin
                    $display("bank %0d command overdue at cycle %0d with the bus idle", b, cycle);
                    stop_with_failure();
                end else if (rr_distance(b) < rr_distance(cmd_bank)) begin
                    $display("bank %0d was granted ahead of waiting bank %0d", cmd_bank, b);
                    stop_with_failure();
                end
            end
        end
        if (cmd_bank >= 0) bus_command(cmd_bank, dram_cmd, dram_row);
        for (int b = 0; b < NUM_BANKS; b++) begin
            check_bit($sformatf("wr_en[%0d]", b), wr_en[b], wr_due[b] == cycle);
            check_bit($sformatf("rd_done[%0d]", b), rd_done[b], rd_due[b] == cycle);
            if (wr_due[b] == cycle) wr_due[b] = -1;
            if (rd_due[b] == cycle) rd_due[b] = -1;
            if (cycle - last_ref[b] > REF_MAX) begin
                $display("bank %0d went %0d cycles without a refresh", b, cycle - last_ref[b]);
                stop_with_failure();
            end
        end
    endtask

    // outputs are settled by the falling edge
    always @(negedge clk) begin
        if (!nRST) begin
            check_op("dram_cmd", dram_cmd, OP_NOP);
        end else begin
            observe_cycle();
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("timeout, the requests did not complete within %0d cycles", WATCHDOG_CYCLES);
        stop_with_failure();
    end

    initial begin
        int gap;
        bit refresh_missing;
        nRST = 1'b0;
        req_valid = 1'b0;
        req_write = 1'b0;
        req_bank = '0;
        req_row = '0;
        for (int b = 0; b < NUM_BANKS; b++) begin
            phase[b] = PH_FREE;
            last_op[b] = OP_NOP;
            last_cycle[b] = 0;
            due[b] = 0;
            wr_due[b] = -1;
            rd_due[b] = -1;
            last_ref[b] = 0;
            ref_count[b] = 0;
        end
        void'($urandom(32'h52ed));
        repeat (2) @(posedge clk);
        #1 nRST = 1'b1;
        for (int n = 0; n < NUM_REQ; n++) begin
            gap = $urandom_range(7, 0);
            // now and then a long gap leaves one bank alone on the bus
            if ($urandom_range(7, 0) == 0) gap = SEQ_WORST;
            repeat (gap) begin
                @(posedge clk);
                #1;
                check_bit("req_ack", req_ack, 1'b0);
            end
            req_valid = 1'b1;
            req_write = 1'($urandom_range(1, 0));
            req_bank = BANK_W'($urandom_range(NUM_BANKS - 1, 0));
            req_row = ROW_W'($urandom());
            do begin
                @(posedge clk);
                #1;
            end while (!req_ack);
            accept_request(int'(req_bank), req_row, req_write);
            req_valid = 1'b0;
        end
        while (!all_quiet()) @(posedge clk);
        repeat (20) @(posedge clk);
        refresh_missing = 1'b0;
        for (int b = 0; b < NUM_BANKS; b++) begin
            if (ref_count[b] == 0) refresh_missing = 1'b1;
        end
        if (refresh_missing) begin
            $display("a bank never issued a refresh during the run");
            stop_with_failure();
        end else begin
            $display("Regression passed");
            $finish;
        end
    end

endmodule
